// File: sim.f
+incdir+include
rtl/bpu_pkg.sv
rtl/ubtb.sv
rtl/btb.sv
rtl/bimodal_table.sv
rtl/s2_control.sv
rtl/branch_predictor.sv
verif/tb_branch_predictor.sv

// File: verif/tb_branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpu_defs.svh"

module tb_branch_predictor;

    localparam int MAX_CYCLES = 400;
    localparam int OFF_W = $clog2(`BLOCK_BYTES);
    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int KEY_W = IDX_W + `BTB_TAG_SIZE;
    localparam logic [`VADDR_SIZE-1:0] ADDR_A = 32'h0000_2040;
    localparam logic [`VADDR_SIZE-1:0] TARGET_T = 32'h0000_3000;

    logic clk;
    logic rst_i;
    logic pred_valid_o;
    logic pred_ready_i;
    logic s2_redirect_o;
    logic squash_valid_i;
    logic update_valid_i;
    bpu_pkg::fetch_block_t pred_o;
    bpu_pkg::squash_t      squash_i;
    bpu_pkg::update_t      update_i;

    // reference state
    logic [`VADDR_SIZE-1:0] exp_start;
    logic                   pend_redirect;
    bpu_pkg::fetch_block_t  exp_rd_block;
    logic                   trained_valid;
    logic [`VADDR_SIZE-1:0] trained_pc;
    logic [`VADDR_SIZE-1:0] trained_tgt;
    logic [1:0]             ctr_model [`BTB_ENTRIES];
    logic [IDX_W-1:0]       upd_idx;
    logic [`VADDR_SIZE-1:0] fth;
    logic [`VADDR_SIZE-1:0] s1_target;
    logic [`VADDR_SIZE-1:0] s2_target;
    logic                   s1_hit;
    logic                   btb_hit;
    logic                   s2_taken;
    logic                   s2_differs;
    logic                   transfer;

    int          xfer_count = 0;
    int          redirect_count = 0;
    int          taken_count = 0;
    int          errors = 0;
    int          cycle_count = 0;
    logic [31:0] rng = 32'hc2994c11;
    string       phase = "reset";

    branch_predictor branch_predictor_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .pred_valid_o   (pred_valid_o),
        .pred_ready_i   (pred_ready_i),
        .pred_o         (pred_o),
        .s2_redirect_o  (s2_redirect_o),
        .squash_valid_i (squash_valid_i),
        .squash_i       (squash_i),
        .update_valid_i (update_valid_i),
        .update_i       (update_i)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    assign transfer = pred_valid_o & pred_ready_i;
    assign upd_idx = update_i.start_pc[OFF_W +: IDX_W];

    // expected stage 1 and stage 2 view of the block at exp_start
    assign fth = exp_start + `BLOCK_BYTES;
    assign s1_hit = trained_valid &&
                    (trained_pc[`VADDR_SIZE-1:OFF_W] == exp_start[`VADDR_SIZE-1:OFF_W]);
    assign btb_hit = trained_valid && (trained_pc[OFF_W +: KEY_W] == exp_start[OFF_W +: KEY_W]);
    assign s1_target = s1_hit ? trained_tgt : fth;
    assign s2_taken = btb_hit && ctr_model[exp_start[OFF_W +: IDX_W]][1];
    assign s2_target = s2_taken ? trained_tgt : fth;
    assign s2_differs = (s2_taken != s1_hit) || (s2_target != s1_target);

    always @(posedge clk) begin
        if (rst_i) begin
            exp_start <= `RESET_PC;
            pend_redirect <= 1'b0;
            exp_rd_block <= '0;
            trained_valid <= 1'b0;
            trained_pc <= '0;
            trained_tgt <= '0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                ctr_model[i] <= 2'd1;
            end
        end else begin
            if (squash_valid_i) begin
                exp_start <= squash_i.target_pc;
                pend_redirect <= 1'b0;
            end else if (transfer) begin
                xfer_count <= xfer_count + 1;
                if (pend_redirect) begin
                    exp_start <= exp_rd_block.target;
                    pend_redirect <= 1'b0;
                    redirect_count <= redirect_count + 1;
                end else begin
                    exp_start <= s1_target;
                    pend_redirect <= s2_differs;
                    exp_rd_block <= '{start_pc: exp_start, target: s2_target, taken: s2_taken};
                    if (s1_hit) taken_count <= taken_count + 1;
                end
            end
            if (update_valid_i && update_i.taken) begin
                trained_valid <= 1'b1;
                trained_pc <= update_i.start_pc;
                trained_tgt <= update_i.target;
                if (ctr_model[upd_idx] != 2'd3) ctr_model[upd_idx] <= ctr_model[upd_idx] + 2'd1;
            end else if (update_valid_i && ctr_model[upd_idx] != 2'd0) begin
                ctr_model[upd_idx] <= ctr_model[upd_idx] - 2'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst_i) pred_valid_o == !squash_valid_i)
    else begin
        errors++;
        $display("MISMATCH %s valid: expected %b actual %b", phase,
                 !$sampled(squash_valid_i), $sampled(pred_valid_o));
    end

    assert property (@(posedge clk) disable iff (rst_i) squash_valid_i |-> !s2_redirect_o)
    else begin
        errors++;
        $display("MISMATCH %s squash redirect: expected 0 actual 1", phase);
    end

    assert property (@(posedge clk) disable iff (rst_i)
        transfer && !pend_redirect |-> pred_o.start_pc == exp_start)
    else begin
        errors++;
        $display("MISMATCH %s start_pc: expected %h actual %h", phase,
                 $sampled(exp_start), $sampled(pred_o.start_pc));
    end

    assert property (@(posedge clk) disable iff (rst_i)
        transfer && !pend_redirect |-> pred_o.target == s1_target && pred_o.taken == s1_hit)
    else begin
        errors++;
        $display("MISMATCH %s stage 1 target/taken: expected %h/%b actual %h/%b", phase,
                 $sampled(s1_target), $sampled(s1_hit),
                 $sampled(pred_o.target), $sampled(pred_o.taken));
    end

    assert property (@(posedge clk) disable iff (rst_i)
        pred_valid_o |-> s2_redirect_o == pend_redirect)
    else begin
        errors++;
        $display("MISMATCH %s redirect: expected %b actual %b", phase,
                 $sampled(pend_redirect), $sampled(s2_redirect_o));
    end

    assert property (@(posedge clk) disable iff (rst_i)
        pred_valid_o && pend_redirect |-> pred_o == exp_rd_block)
    else begin
        errors++;
        $display("MISMATCH %s redirect block: expected %h actual %h", phase,
                 $sampled(exp_rd_block), $sampled(pred_o));
    end

    // stalled output holds until taken
    assert property (@(posedge clk) disable iff (rst_i)
        $past(pred_valid_o && !pred_ready_i) && !squash_valid_i
        |-> pred_o == $past(pred_o) && s2_redirect_o == $past(s2_redirect_o))
    else begin
        errors++;
        $display("MISMATCH %s hold: expected %h/%b actual %h/%b", phase,
                 $past(pred_o), $past(s2_redirect_o), $sampled(pred_o), $sampled(s2_redirect_o));
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic run_blocks(input int n, input bit random_ready);
        int goal;
        goal = xfer_count + n;
        while (xfer_count < goal) begin
            @(negedge clk);
            if (random_ready) begin
                rng = xorshift32(rng);
                pred_ready_i = (rng[1:0] != 2'b00);
            end else begin
                pred_ready_i = 1'b1;
            end
        end
    endtask

    // called on a falling edge, squash covers the cycle in progress
    task automatic issue_squash(input logic [`VADDR_SIZE-1:0] pc);
        squash_valid_i = 1'b1;
        squash_i.target_pc = pc;
        @(negedge clk);
        squash_valid_i = 1'b0;
    endtask

    task automatic send_update(input logic [`VADDR_SIZE-1:0] pc, input logic taken);
        @(negedge clk);
        update_valid_i = 1'b1;
        update_i = '{start_pc: pc, br_offset: 2'd2, target: TARGET_T, taken: taken};
        @(negedge clk);
        update_valid_i = 1'b0;
    endtask

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_i = 1'b1;
        pred_ready_i = 1'b0;
        squash_valid_i = 1'b0;
        squash_i = '0;
        update_valid_i = 1'b0;
        update_i = '0;
        repeat (10) @(negedge clk);
        rst_i = 1'b0;

        phase = "sequential";
        run_blocks(8, 1'b0);
        phase = "squash";
        issue_squash(32'h0000_8000);
        run_blocks(4, 1'b0);

        phase = "trained";
        send_update(ADDR_A, 1'b1);
        issue_squash(32'h0000_2000);
        run_blocks(8, 1'b0);

        // counter falls to 0, micro BTB still says taken
        phase = "override";
        send_update(ADDR_A, 1'b0);
        send_update(ADDR_A, 1'b0);
        issue_squash(32'h0000_2000);
        // stop right after A so the next squash lands on its redirect
        run_blocks(5, 1'b0);
        phase = "redirect squash";
        issue_squash(32'h0000_2000);
        phase = "override";
        run_blocks(10, 1'b0);

        phase = "stall";
        issue_squash(32'h0000_2000);
        run_blocks(40, 1'b1);

        phase = "done";
        @(negedge clk);
        if (taken_count == 0) begin
            errors++;
            $display("no trained taken block was ever fetched");
        end
        if (redirect_count == 0) begin
            errors++;
            $display("no stage 2 redirect was ever accepted");
        end
        $display("transfers %0d, taken %0d, redirects %0d, errors %0d",
                 xfer_count, taken_count, redirect_count, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpu_defs.svh"

module branch_predictor (
    input  logic                    clk,
    input  logic                    rst_i,
    output logic                    pred_valid_o,
    input  logic                    pred_ready_i,
    output bpu_pkg::fetch_block_t   pred_o,
    output logic                    s2_redirect_o,
    input  logic                    squash_valid_i,
    input  bpu_pkg::squash_t        squash_i,
    input  logic                    update_valid_i,
    input  bpu_pkg::update_t        update_i
);

    logic [`VADDR_SIZE-1:0] pc_q;

    // stage 2 register
    bpu_pkg::fetch_block_t  s2_q;
    logic                   s2_valid_q;

    bpu_pkg::fetch_block_t  s1_block;
    bpu_pkg::fetch_block_t  s2_block;
    bpu_pkg::btb_entry_t    btb_entry;
    logic                   dir_taken;
    logic                   mismatch;
    logic                   advance;

    ubtb ubtb_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .pc_i           (pc_q),
        .update_valid_i (update_valid_i),
        .update_i       (update_i),
        .pred_o         (s1_block)
    );

    btb btb_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .rd_en_i        (advance),
        .pc_i           (pc_q),
        .update_valid_i (update_valid_i),
        .update_i       (update_i),
        .entry_o        (btb_entry)
    );

    bimodal_table bimodal_table_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .rd_en_i        (advance),
        .pc_i           (pc_q),
        .update_valid_i (update_valid_i),
        .update_i       (update_i),
        .taken_o        (dir_taken)
    );

    s2_control s2_control_i (
        .s1_block_i     (s2_q),
        .entry_i        (btb_entry),
        .dir_taken_i    (dir_taken),
        .s2_block_o     (s2_block),
        .mismatch_o     (mismatch)
    );

    // squash wins over everything in its cycle
    assign pred_valid_o = ~rst_i & ~squash_valid_i;
    assign s2_redirect_o = s2_valid_q & mismatch & ~squash_valid_i;
    assign pred_o = s2_redirect_o ? s2_block : s1_block;

    assign advance = pred_ready_i | ~pred_valid_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `RESET_PC;
            s2_valid_q <= 1'b0;
        end else if (squash_valid_i) begin
            pc_q <= squash_i.target_pc;
            s2_valid_q <= 1'b0;
        end else if (advance) begin
            pc_q <= pred_o.target;
            // a redirected block is not rechecked
            s2_valid_q <= ~s2_redirect_o;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !s2_redirect_o) begin
            s2_q <= s1_block;
        end
    end

endmodule

`default_nettype wire

// File: rtl/s2_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpu_defs.svh"

module s2_control (
    input  bpu_pkg::fetch_block_t   s1_block_i,
    input  bpu_pkg::btb_entry_t     entry_i,
    input  logic                    dir_taken_i,
    output bpu_pkg::fetch_block_t   s2_block_o,
    output logic                    mismatch_o
);

    logic [`BTB_TAG_SIZE-1:0] lookup_tag;
    logic [`VADDR_SIZE-1:0]   fth_pc;
    logic                     hit;
    logic                     pred_taken;
    logic                     target_diff;
    logic                     taken_diff;

    assign lookup_tag = bpu_pkg::btb_tag(s1_block_i.start_pc);
    assign fth_pc = bpu_pkg::fallthrough(s1_block_i.start_pc);

    assign hit = entry_i.valid && (entry_i.tag == lookup_tag);

    // counter upper bit set means 2 or 3
    assign pred_taken = hit & dir_taken_i;

    always_comb begin
        s2_block_o.start_pc = s1_block_i.start_pc;
        s2_block_o.taken = pred_taken;
        if (pred_taken) begin
            s2_block_o.target = entry_i.target;
        end else begin
            s2_block_o.target = fth_pc;
        end
    end

    // compared against what stage 1 already sent out
    assign target_diff = s2_block_o.target != s1_block_i.target;
    assign taken_diff = s2_block_o.taken != s1_block_i.taken;

    // not qualified by stage 2 valid here
    assign mismatch_o = target_diff | taken_diff;

endmodule

`default_nettype wire

// File: rtl/bimodal_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpu_defs.svh"

module bimodal_table (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    rd_en_i,
    input  logic [`VADDR_SIZE-1:0]  pc_i,
    input  logic                    update_valid_i,
    input  bpu_pkg::update_t        update_i,
    output logic                    taken_o
);

    localparam int unsigned IDX_W = bpu_pkg::BTB_IDX_W;

    logic [1:0]       ctr_q [`BTB_ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [1:0]       cur_ctr;
    logic [1:0]       next_ctr;

    assign rd_idx = bpu_pkg::btb_index(pc_i);
    assign wr_idx = bpu_pkg::btb_index(update_i.start_pc);
    assign cur_ctr = ctr_q[wr_idx];

    // saturating step
    always_comb begin
        if (update_i.taken) begin
            next_ctr = (cur_ctr == 2'd3) ? cur_ctr : cur_ctr + 2'd1;
        end else begin
            next_ctr = (cur_ctr == 2'd0) ? cur_ctr : cur_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // weakly not taken
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                ctr_q[i] <= 2'd1;
            end
        end else if (update_valid_i) begin
            ctr_q[wr_idx] <= next_ctr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            taken_o <= 1'b0;
        end else if (rd_en_i) begin
            taken_o <= ctr_q[rd_idx][1];
        end
    end

endmodule

`default_nettype wire

// File: rtl/btb.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpu_defs.svh"

module btb (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    rd_en_i,
    input  logic [`VADDR_SIZE-1:0]  pc_i,
    input  logic                    update_valid_i,
    input  bpu_pkg::update_t        update_i,
    output bpu_pkg::btb_entry_t     entry_o
);

    localparam int unsigned IDX_W = bpu_pkg::BTB_IDX_W;

    logic [`BTB_ENTRIES-1:0]    valid_q;
    logic [`BTB_TAG_SIZE-1:0]   tag_mem [`BTB_ENTRIES];
    logic [`BR_OFFSET_SIZE-1:0] offset_mem [`BTB_ENTRIES];
    logic [`VADDR_SIZE-1:0]     target_mem [`BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_en;

    assign rd_idx = bpu_pkg::btb_index(pc_i);
    assign wr_idx = bpu_pkg::btb_index(update_i.start_pc);
    assign wr_en = update_valid_i & update_i.taken;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx] <= bpu_pkg::btb_tag(update_i.start_pc);
            offset_mem[wr_idx] <= update_i.br_offset;
            target_mem[wr_idx] <= update_i.target;
        end
    end

    // read lines up with the stage 2 register, tag check happens there
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            entry_o.valid <= valid_q[rd_idx];
            entry_o.tag <= tag_mem[rd_idx];
            entry_o.br_offset <= offset_mem[rd_idx];
            entry_o.target <= target_mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: rtl/ubtb.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpu_defs.svh"

module ubtb (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic [`VADDR_SIZE-1:0]  pc_i,
    input  logic                    update_valid_i,
    input  bpu_pkg::update_t        update_i,
    output bpu_pkg::fetch_block_t   pred_o
);

    localparam int unsigned IDX_W = bpu_pkg::UBTB_IDX_W;
    localparam int unsigned TAG_LSB = bpu_pkg::BLOCK_OFF_W + IDX_W;
    localparam int unsigned TAG_W = `VADDR_SIZE - TAG_LSB;

    logic [`UBTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]         tag_mem [`UBTB_ENTRIES];
    logic [`VADDR_SIZE-1:0]   target_mem [`UBTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_en;
    logic             hit;

    assign rd_idx = pc_i[bpu_pkg::BLOCK_OFF_W +: IDX_W];
    assign wr_idx = update_i.start_pc[bpu_pkg::BLOCK_OFF_W +: IDX_W];

    // only taken branches allocate
    assign wr_en = update_valid_i & update_i.taken;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx] <= update_i.start_pc[`VADDR_SIZE-1:TAG_LSB];
            target_mem[wr_idx] <= update_i.target;
        end
    end

    // same-cycle lookup
    assign hit = valid_q[rd_idx] && (tag_mem[rd_idx] == pc_i[`VADDR_SIZE-1:TAG_LSB]);

    always_comb begin
        pred_o.start_pc = pc_i;
        pred_o.taken = hit;
        if (hit) begin
            pred_o.target = target_mem[rd_idx];
        end else begin
            pred_o.target = bpu_pkg::fallthrough(pc_i);
        end
    end

endmodule

`default_nettype wire

// File: rtl/bpu_pkg.sv
`default_nettype none

`include "bpu_defs.svh"

package bpu_pkg;

    localparam int unsigned BLOCK_OFF_W = $clog2(`BLOCK_BYTES);
    localparam int unsigned BTB_IDX_W = $clog2(`BTB_ENTRIES);
    localparam int unsigned UBTB_IDX_W = $clog2(`UBTB_ENTRIES);

    typedef logic [`VADDR_SIZE-1:0] vaddr_t;

    typedef struct packed {
        vaddr_t start_pc;
        vaddr_t target;
        logic   taken;
    } fetch_block_t;

    typedef struct packed {
        logic                       valid;
        logic [`BTB_TAG_SIZE-1:0]   tag;
        logic [`BR_OFFSET_SIZE-1:0] br_offset;
        vaddr_t                     target;
    } btb_entry_t;

    typedef struct packed {
        vaddr_t target_pc;
    } squash_t;

    typedef struct packed {
        vaddr_t                     start_pc;
        logic [`BR_OFFSET_SIZE-1:0] br_offset;
        vaddr_t                     target;
        logic                       taken;
    } update_t;

    // shared by btb, bimodal_table and stage 2
    function automatic logic [BTB_IDX_W-1:0] btb_index(input vaddr_t pc);
        return pc[BLOCK_OFF_W +: BTB_IDX_W];
    endfunction

    function automatic logic [`BTB_TAG_SIZE-1:0] btb_tag(input vaddr_t pc);
        return pc[BLOCK_OFF_W + BTB_IDX_W +: `BTB_TAG_SIZE];
    endfunction

    // next sequential block
    function automatic vaddr_t fallthrough(input vaddr_t pc);
        return pc + vaddr_t'(`BLOCK_BYTES);
    endfunction

endpackage

`default_nettype wire

// File: include/bpu_defs.svh
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// address and fetch geometry
`define VADDR_SIZE 32
`define RESET_PC 32'h0000_1000
`define BLOCK_BYTES 16

// table sizes
`define BTB_ENTRIES 64
`define UBTB_ENTRIES 16
`define BTB_TAG_SIZE 8

// word offset of the branch inside a block
`define BR_OFFSET_SIZE 2

`endif
